/* csr_unit.f */
+incdir+dv
rtl/csr_pkg.sv
rtl/csr_issue_queue.sv
rtl/csr_operand_read.sv
rtl/csr_exec.sv
rtl/csr_unit_top.sv
dv/csr_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module csr_unit_tb \
    -f csr_unit.f -o csr_unit_sim

out=$(./obj_dir/csr_unit_sim) || true
echo "$out"

if grep -q "Simulation passed" <<< "$out"; then
    exit 0
fi
exit 1

/* dv/csr_unit_model.svh */
`ifndef CSR_UNIT_MODEL_SVH
`define CSR_UNIT_MODEL_SVH

logic [csr_pkg::xlen-1:0] shadow_csr [4];
logic [csr_pkg::xlen-1:0] prf_vals [32];
csr_pkg::dispatch_entry_t exp_q [$];   // dispatched, no wb yet.
int                       exp_cycle_q [$];

function automatic int csr_slot(input logic [11:0] addr);
    case (addr)
        csr_pkg::mscratch: return 0;
        csr_pkg::mtvec:    return 1;
        csr_pkg::mepc:     return 2;
        csr_pkg::satp:     return 3;
        default:           return -1;
    endcase
endfunction

function automatic bit is_csr_op(input csr_pkg::csr_op_e op);
    return op == csr_pkg::csr_rw || op == csr_pkg::csr_rs || op == csr_pkg::csr_rc;
endfunction

function automatic logic [31:0] csr_model_exec(input csr_pkg::csr_op_e op,
                                               input logic [31:0] old,
                                               input logic [31:0] src);
    if (op == csr_pkg::csr_rs) return old | src;
    if (op == csr_pkg::csr_rc) return old & ~src;
    return src;
endfunction

function automatic csr_pkg::fence_req_t fence_model(input csr_pkg::dispatch_entry_t e,
                                                     input logic [31:0] src);
    csr_pkg::fence_req_t f;
    f = '0;
    f.kind = e.op;
    f.rob_idx = e.rob_idx;
    f.valid = !is_csr_op(e.op) || csr_slot(e.csr_addr) == 3;   // satp write.
    if (e.op == csr_pkg::op_sfence_vma) begin
        f.vaddr = src;
        f.clear_all = src == 0;
    end
    return f;
endfunction

// younger means 1 to 31 steps ahead on the rob ring.
function automatic bit survives_redirect(input logic [5:0] idx, input logic [5:0] r);
    logic [5:0] d;
    d = idx - r;
    return d == 0 || d[5];
endfunction

task automatic predict(input csr_pkg::dispatch_entry_t e, output csr_pkg::wb_t w,
                       output csr_pkg::fence_req_t f);
    int slot;
    logic [31:0] src;
    slot = csr_slot(e.csr_addr);
    src = prf_vals[e.rs1];
    w = '0;
    w.valid = 1'b1;
    w.rd = e.rd;
    w.rd_we = e.rd_we;
    w.rob_idx = e.rob_idx;
    if (is_csr_op(e.op) && slot < 0) begin
        w.illegal = 1'b1;
    end else if (is_csr_op(e.op)) begin
        w.old_value = shadow_csr[slot];
        shadow_csr[slot] = csr_model_exec(e.op, shadow_csr[slot], src);
    end
    f = fence_model(e, src);
endtask

task automatic check_wb(input csr_pkg::wb_t exp, input csr_pkg::wb_t act);
    if (exp !== act) begin
        fail_now($sformatf("ERR %0t wb exp=%h act=%h", $time, exp, act));
    end
endtask

task automatic check_fence(input csr_pkg::fence_req_t exp, input csr_pkg::fence_req_t act);
    if (exp.valid !== act.valid || (exp.valid && exp !== act)) begin
        fail_now($sformatf("ERR %0t fence_req exp=%h act=%h", $time, exp, act));
    end
endtask

task automatic check_credit(input csr_pkg::credit_ret_t exp, input csr_pkg::credit_ret_t act);
    if (exp !== act) begin
        fail_now($sformatf("ERR %0t credit_ret exp=%h act=%h", $time, exp, act));
    end
endtask

`endif

/* dv/csr_unit_tb.sv */
`default_nettype none

module csr_unit_tb;

    logic                          clk;
    logic                          rst;
    logic                          dispatch_valid;
    csr_pkg::dispatch_entry_t      dispatch_entry;
    csr_pkg::credit_ret_t          credit_ret;
    logic [csr_pkg::rob_width-1:0] commit_rob_idx;
    csr_pkg::redirect_t            redirect;
    csr_pkg::prf_write_t           prf_write;
    csr_pkg::wb_t                  wb;
    csr_pkg::fence_req_t           fence_req;

    int         credit;
    int         cycle = 0;
    int         commit_cycle;
    int         redirect_cycle_q [$];   // cycles that carried a redirect.
    int         commit_delay;
    int         wb_count;
    logic       pend_pop;   // wb seen, head not popped yet.
    logic [5:0] pend_idx;
    logic [5:0] next_rob;

    `include "csr_unit_model.svh"

    csr_unit_top u_csr_unit_top (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_entry (dispatch_entry),
        .credit_ret     (credit_ret),
        .commit_rob_idx (commit_rob_idx),
        .redirect       (redirect),
        .prf_write      (prf_write),
        .wb             (wb),
        .fence_req      (fence_req)
    );

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic compare_cycle();
        csr_pkg::credit_ret_t exp_credit;
        csr_pkg::wb_t         exp_wb;
        csr_pkg::fence_req_t  exp_fence;
        int n;
        int ready;
        n = 0;
        if (pend_pop && commit_rob_idx != pend_idx) begin
            n = 1;   // head retires.
            pend_pop = 1'b0;
        end
        while (redirect.valid && exp_q.size() > 0 &&
               !survives_redirect(exp_q[$].rob_idx, redirect.rob_idx)) begin
            void'(exp_q.pop_back());
            void'(exp_cycle_q.pop_back());
            n++;
        end
        exp_credit.valid = n != 0;
        exp_credit.count = n[csr_pkg::iq_idx_width:0];
        check_credit(exp_credit, credit_ret);
        if (credit_ret.valid) credit += int'(credit_ret.count);
        if (credit < 0 || credit > csr_pkg::iq_depth) begin
            fail_now($sformatf("ERR %0t credit exp=0..8 act=%0d", $time, credit));
        end
        if (wb.valid) begin
            if (exp_q.size() == 0 || pend_pop) begin
                fail_now("writeback seen with no op waiting for one");
            end
            if (commit_rob_idx != exp_q[0].rob_idx) begin
                fail_now($sformatf("ERR %0t commit_rob_idx exp=%0d act=%0d", $time,
                                   exp_q[0].rob_idx, commit_rob_idx));
            end
            ready = (commit_cycle > exp_cycle_q[0] ? commit_cycle : exp_cycle_q[0]) + 3;
            foreach (redirect_cycle_q[i]) begin
                if (redirect_cycle_q[i] == ready - 2) ready++;   // select held off.
            end
            if (cycle != ready) begin
                fail_now($sformatf("ERR %0t wb_cycle exp=%0d act=%0d", $time, ready, cycle));
            end
            predict(exp_q[0], exp_wb, exp_fence);
            check_wb(exp_wb, wb);
            check_fence(exp_fence, fence_req);
            pend_pop = 1'b1;
            pend_idx = wb.rob_idx;
            void'(exp_q.pop_front());
            void'(exp_cycle_q.pop_front());
            wb_count++;
        end else if (fence_req.valid) begin
            fail_now("fence request seen without a writeback");
        end
    endtask

    // outputs settle well before the falling edge.
    always @(negedge clk) begin
        if (!rst) compare_cycle();
    end

    function automatic logic [11:0] pick_addr(input int sel);
        case (sel)
            0, 1:    return csr_pkg::mscratch;
            2, 3:    return csr_pkg::mtvec;
            4, 5:    return csr_pkg::mepc;
            6, 7:    return csr_pkg::satp;
            default: return 12'h7c0;   // not implemented.
        endcase
    endfunction

    task automatic drive_cycle(input bit active);
        csr_pkg::dispatch_entry_t e;
        int pick;
        dispatch_valid = 1'b0;
        redirect = '0;
        if (pend_pop && commit_rob_idx == pend_idx) begin
            if (commit_delay == 0) begin
                commit_rob_idx = commit_rob_idx + 6'd1;
                commit_cycle = cycle;
                commit_delay = $urandom_range(0, 3);
            end else begin
                commit_delay--;
            end
        end
        if (active && exp_q.size() > 0 && $urandom_range(0, 39) == 0) begin
            pick = $urandom_range(0, exp_q.size());
            redirect.valid = 1'b1;
            if (pick == 0) begin
                redirect.rob_idx = exp_q[0].rob_idx - 6'd1;   // kills the op in flight too.
            end else begin
                redirect.rob_idx = exp_q[pick-1].rob_idx;
            end
            next_rob = redirect.rob_idx + 6'd1;
            redirect_cycle_q.push_back(cycle);
        end else if (active && credit > 0 && $urandom_range(0, 1) == 1) begin
            e.op = csr_pkg::csr_op_e'(3'($urandom_range(0, 5)));
            e.csr_addr = pick_addr($urandom_range(0, 8));
            e.rs1 = 5'($urandom);
            e.rs2 = 5'($urandom);
            e.rd = 5'($urandom);
            e.rd_we = 1'($urandom);
            e.rob_idx = next_rob;
            next_rob = next_rob + 6'd1;
            dispatch_valid = 1'b1;
            dispatch_entry = e;
            credit--;
            exp_q.push_back(e);
            exp_cycle_q.push_back(cycle);
        end
    endtask

    initial begin
        int wait_cnt;
        void'($urandom(35));
        rst = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_entry = '0;
        commit_rob_idx = '0;
        redirect = '0;
        prf_write = '0;
        credit = csr_pkg::iq_depth;
        commit_cycle = 0;
        commit_delay = 0;
        wb_count = 0;
        pend_pop = 1'b0;
        pend_idx = '0;
        next_rob = '0;
        for (int i = 0; i < 4; i++) shadow_csr[i] = '0;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        for (int i = 0; i < 32; i++) begin
            prf_vals[i] = (i % 8 == 0) ? '0 : $urandom;   // zeros give clear-all.
            prf_write.valid = 1'b1;
            prf_write.idx = 5'(i);
            prf_write.data = prf_vals[i];
            @(posedge clk);
            #1;
        end
        prf_write = '0;
        for (int c = 0; c < 4000; c++) begin
            drive_cycle(1'b1);
            @(posedge clk);
            #1;
        end
        wait_cnt = 0;
        while (exp_q.size() != 0 || pend_pop) begin
            drive_cycle(1'b0);
            @(posedge clk);
            #1;
            wait_cnt++;
            if (wait_cnt > 500) fail_now("timeout while waiting for the queue to drain");
        end
        if (credit == csr_pkg::iq_depth && wb_count > 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            fail_now($sformatf("ERR %0t credit exp=%0d act=%0d (wb count %0d)", $time,
                               csr_pkg::iq_depth, credit, wb_count));
        end
    end

endmodule

`default_nettype wire

/* rtl/csr_unit_top.sv */
`default_nettype none

module csr_unit_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            dispatch_valid,
    input  csr_pkg::dispatch_entry_t        dispatch_entry,
    output csr_pkg::credit_ret_t            credit_ret,
    input  logic [csr_pkg::rob_width-1:0]   commit_rob_idx,
    input  csr_pkg::redirect_t              redirect,
    input  csr_pkg::prf_write_t             prf_write,
    output csr_pkg::wb_t                    wb,
    output csr_pkg::fence_req_t             fence_req
);

    logic                   issue_valid;
    csr_pkg::issue_t        issue;
    logic                   exec_valid;
    csr_pkg::exec_req_t     exec_req;

    // select in cycle 0.
    csr_issue_queue u_issue_queue (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_entry (dispatch_entry),
        .credit_ret     (credit_ret),
        .commit_rob_idx (commit_rob_idx),
        .redirect       (redirect),
        .issue_valid    (issue_valid),
        .issue          (issue)
    );

    // operands registered for cycle 1.
    csr_operand_read u_operand_read (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .prf_write   (prf_write),
        .exec_valid  (exec_valid),
        .exec_req    (exec_req)
    );

    // wb and fence_req registered for cycle 2.
    csr_exec u_exec (
        .clk        (clk),
        .rst        (rst),
        .exec_valid (exec_valid),
        .exec_req   (exec_req),
        .redirect   (redirect),
        .wb         (wb),
        .fence_req  (fence_req)
    );

endmodule

`default_nettype wire

/* rtl/csr_exec.sv */
`default_nettype none

module csr_exec (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    exec_valid,
    input  csr_pkg::exec_req_t      exec_req,
    input  csr_pkg::redirect_t      redirect,
    output csr_pkg::wb_t            wb,
    output csr_pkg::fence_req_t     fence_req
);

    logic [csr_pkg::xlen-1:0]          csr_q [csr_pkg::csr_count];
    logic [csr_pkg::csr_sel_width-1:0] csr_sel;
    logic [csr_pkg::xlen-1:0]          old_val;
    logic [csr_pkg::xlen-1:0]          new_val;
    logic                              legal;
    logic                              is_csr;
    logic                              is_sfence;
    logic                              fence_hit;
    logic                              kill_s1;
    logic                              kill_s2;
    logic                              fire;
    csr_pkg::wb_t                      wb_q;
    csr_pkg::fence_req_t               fence_q;
    logic                              pend_valid;
    logic [csr_pkg::csr_sel_width-1:0] pend_sel;
    logic [csr_pkg::xlen-1:0]          pend_data;

    always_comb begin
        legal = 1'b1;
        csr_sel = '0;
        case (exec_req.entry.csr_addr)
            csr_pkg::mscratch: csr_sel = 2'd0;
            csr_pkg::mtvec:    csr_sel = 2'd1;
            csr_pkg::mepc:     csr_sel = 2'd2;
            csr_pkg::satp:     csr_sel = 2'd3;
            default:           legal = 1'b0;
        endcase
    end

    assign is_csr = exec_req.entry.op inside {csr_pkg::csr_rw, csr_pkg::csr_rs, csr_pkg::csr_rc};
    assign is_sfence = exec_req.entry.op == csr_pkg::op_sfence_vma;
    assign old_val = (is_csr && legal) ? csr_q[csr_sel] : '0;

    always_comb begin
        case (exec_req.entry.op)
            csr_pkg::csr_rs: new_val = old_val | exec_req.src1;
            csr_pkg::csr_rc: new_val = old_val & ~exec_req.src1;
            default:         new_val = exec_req.src1;
        endcase
    end

    // every csr op to satp counts as a write of it.
    assign fence_hit = exec_req.entry.op inside {csr_pkg::op_fence, csr_pkg::op_fence_i,
                                                 csr_pkg::op_sfence_vma} ||
                       (is_csr && legal && exec_req.entry.csr_addr == csr_pkg::satp);

    assign kill_s1 = redirect.valid &&
                     csr_pkg::rob_younger(exec_req.entry.rob_idx, redirect.rob_idx);
    assign kill_s2 = redirect.valid && csr_pkg::rob_younger(wb_q.rob_idx, redirect.rob_idx);
    assign fire = exec_valid && !kill_s1;

    // CSR update is held one cycle so a late redirect can still cancel it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < csr_pkg::csr_count; i++) begin
                csr_q[i] <= '0;
            end
            wb_q <= '0;
            fence_q <= '0;
            pend_valid <= 1'b0;
            pend_sel <= '0;
            pend_data <= '0;
        end else begin
            if (pend_valid && !kill_s2) begin
                csr_q[pend_sel] <= pend_data;
            end
            wb_q.valid <= fire;
            fence_q.valid <= fire && fence_hit;
            pend_valid <= fire && is_csr && legal;
            if (exec_valid) begin
                wb_q.rd <= exec_req.entry.rd;
                wb_q.rd_we <= exec_req.entry.rd_we;
                wb_q.old_value <= old_val;
                wb_q.illegal <= is_csr && !legal;
                wb_q.rob_idx <= exec_req.entry.rob_idx;
                fence_q.kind <= exec_req.entry.op;
                fence_q.clear_all <= is_sfence && exec_req.src1 == '0;
                fence_q.vaddr <= is_sfence ? exec_req.src1 : '0;
                fence_q.rob_idx <= exec_req.entry.rob_idx;
                pend_sel <= csr_sel;
                pend_data <= new_val;
            end
        end
    end

    always_comb begin
        wb = wb_q;
        wb.valid = wb_q.valid && !kill_s2;   // killed in stage 2.
        fence_req = fence_q;
        fence_req.valid = fence_q.valid && !kill_s2;
    end

endmodule

`default_nettype wire

/* rtl/csr_operand_read.sv */
`default_nettype none

module csr_operand_read (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issue_valid,
    input  csr_pkg::issue_t         issue,
    input  csr_pkg::prf_write_t     prf_write,
    output logic                    exec_valid,
    output csr_pkg::exec_req_t      exec_req
);

    logic [csr_pkg::xlen-1:0] prf [csr_pkg::prf_depth];
    logic [csr_pkg::xlen-1:0] src1;
    logic [csr_pkg::xlen-1:0] src2;

    // same-cycle write wins over the array contents
    function automatic logic [csr_pkg::xlen-1:0] prf_read(
        input logic [csr_pkg::preg_width-1:0] idx
    );
        if (prf_write.valid && prf_write.idx == idx) begin
            return prf_write.data;
        end
        return prf[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (prf_write.valid) begin
            prf[prf_write.idx] <= prf_write.data;
        end
    end

    assign src1 = prf_read(issue.entry.rs1);
    assign src2 = prf_read(issue.entry.rs2);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exec_valid <= 1'b0;
        end else begin
            exec_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            exec_req.entry <= issue.entry;
            exec_req.src1 <= src1;
            exec_req.src2 <= src2;
        end
    end

endmodule

`default_nettype wire

/* rtl/csr_issue_queue.sv */
`default_nettype none

module csr_issue_queue (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            dispatch_valid,
    input  csr_pkg::dispatch_entry_t        dispatch_entry,
    output csr_pkg::credit_ret_t            credit_ret,
    input  logic [csr_pkg::rob_width-1:0]   commit_rob_idx,
    input  csr_pkg::redirect_t              redirect,
    output logic                            issue_valid,
    output csr_pkg::issue_t                 issue
);

    typedef enum logic {idle, wait_commit} state_e;
    typedef logic [csr_pkg::iq_idx_width-1:0] idx_t;
    typedef logic [csr_pkg::iq_idx_width:0] ptr_t;   // {dir, idx}.

    csr_pkg::dispatch_entry_t mem [csr_pkg::iq_depth];
    csr_pkg::dispatch_entry_t head_entry;
    state_e                   state;
    logic [1:0]               wait_cnt;
    idx_t                     head;
    idx_t                     tail;
    logic                     hdir;
    logic                     tdir;
    ptr_t                     occupancy;
    ptr_t                     kill_cnt;
    ptr_t                     tail_base;
    ptr_t                     tail_next;
    ptr_t                     head_next;
    logic [csr_pkg::iq_depth-1:0] kill;
    logic                     empty;
    logic                     select;
    logic                     head_killed;
    logic                     pop;
    logic                     enq_drop;
    logic                     enqueue;

    assign occupancy = {tdir, tail} - {hdir, head};
    assign empty = occupancy == '0;
    assign head_entry = mem[head];

    // entries are kept in age order, so the killed ones form a suffix.
    always_comb begin
        idx_t offset;
        kill = '0;
        kill_cnt = '0;
        for (int i = 0; i < csr_pkg::iq_depth; i++) begin
            offset = idx_t'(i) - head;
            kill[i] = redirect.valid && ({1'b0, offset} < occupancy) &&
                      csr_pkg::rob_younger(mem[i].rob_idx, redirect.rob_idx);
            kill_cnt = kill_cnt + ptr_t'(kill[i]);
        end
    end

    assign head_killed = kill[head];

    assign select = !empty && state == idle &&
                    head_entry.rob_idx == commit_rob_idx && !redirect.valid;

    // wait_cnt reaches 2 on the cycle after writeback.
    assign pop = state == wait_commit && wait_cnt == 2'd2 &&
                 commit_rob_idx != head_entry.rob_idx && !head_killed;

    // a beat arriving with a redirect that kills it is dropped.
    assign enq_drop = dispatch_valid && redirect.valid &&
                      csr_pkg::rob_younger(dispatch_entry.rob_idx, redirect.rob_idx);
    assign enqueue = dispatch_valid && !enq_drop;

    assign tail_base = {tdir, tail} - kill_cnt;
    assign tail_next = tail_base + ptr_t'(enqueue);
    assign head_next = {hdir, head} + ptr_t'(pop);

    always_comb begin
        credit_ret.count = kill_cnt + ptr_t'(pop) + ptr_t'(enq_drop);
        credit_ret.valid = credit_ret.count != '0;
    end

    assign issue_valid = select;
    assign issue.entry = head_entry;

    always_ff @(posedge clk) begin
        if (enqueue) begin
            mem[tail_base[csr_pkg::iq_idx_width-1:0]] <= dispatch_entry;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head <= '0;
            hdir <= 1'b0;
            tail <= '0;
            tdir <= 1'b0;
        end else begin
            {hdir, head} <= head_next;
            {tdir, tail} <= tail_next;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= idle;
            wait_cnt <= '0;
        end else begin
            case (state)
                idle: begin
                    if (select) begin
                        state <= wait_commit;
                        wait_cnt <= '0;
                    end
                end
                wait_commit: begin
                    if (head_killed || pop) begin
                        state <= idle;   // op is gone or retired.
                    end else if (wait_cnt != 2'd2) begin
                        wait_cnt <= wait_cnt + 2'd1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    localparam int rob_width = 6;
    localparam int iq_depth = 8;
    localparam int iq_idx_width = 3;
    localparam int preg_width = 5;
    localparam int prf_depth = 1 << preg_width;
    localparam int xlen = 32;
    localparam int csr_addr_width = 12;
    localparam int csr_count = 4;
    localparam int csr_sel_width = 2;

    typedef enum logic [2:0] {
        csr_rw,
        csr_rs,
        csr_rc,
        op_fence,
        op_fence_i,
        op_sfence_vma
    } csr_op_e;

    typedef enum logic [csr_addr_width-1:0] {
        mscratch = 12'h340,
        mtvec    = 12'h305,
        mepc     = 12'h341,
        satp     = 12'h180
    } csr_addr_e;

    typedef struct packed {
        csr_op_e                   op;
        logic [csr_addr_width-1:0] csr_addr;   // raw, may be unimplemented.
        logic [preg_width-1:0]     rs1;
        logic [preg_width-1:0]     rs2;
        logic [preg_width-1:0]     rd;
        logic                      rd_we;
        logic [rob_width-1:0]      rob_idx;
    } dispatch_entry_t;

    typedef struct packed {
        logic                  valid;
        logic [iq_idx_width:0] count;   // freed slots.
    } credit_ret_t;

    typedef struct packed {
        dispatch_entry_t entry;
    } issue_t;

    typedef struct packed {
        dispatch_entry_t   entry;
        logic [xlen-1:0]   src1;
        logic [xlen-1:0]   src2;
    } exec_req_t;

    typedef struct packed {
        logic                  valid;
        logic [preg_width-1:0] idx;
        logic [xlen-1:0]       data;
    } prf_write_t;

    typedef struct packed {
        logic                 valid;
        logic [rob_width-1:0] rob_idx;
    } redirect_t;

    typedef struct packed {
        logic                  valid;
        logic [preg_width-1:0] rd;
        logic                  rd_we;
        logic [xlen-1:0]       old_value;
        logic                  illegal;
        logic [rob_width-1:0]  rob_idx;
    } wb_t;

    typedef struct packed {
        logic                 valid;
        csr_op_e              kind;
        logic                 clear_all;   // sfence.vma with zero address.
        logic [xlen-1:0]      vaddr;
        logic [rob_width-1:0] rob_idx;
    } fence_req_t;

    // top bit of a rob index flips on every wrap of the slot field
    function automatic logic rob_younger(input logic [rob_width-1:0] a,
                                         input logic [rob_width-1:0] b);
        if (a[rob_width-1] == b[rob_width-1]) begin
            return a[rob_width-2:0] > b[rob_width-2:0];
        end
        return a[rob_width-2:0] < b[rob_width-2:0];
    endfunction

endpackage

`default_nettype wire
